//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_writeback_core
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- cdb_pkg.sv
package cdb_pkg;

	//////////////////////////////
	// widths
	localparam int DATA_WIDTH = 32;
	localparam int TAG_WIDTH = 6;
	localparam int N_READ = 2;

	// reservation depths
	localparam int GPR_SLOTS = 3;
	localparam int FPR_SLOTS = 14;

	// entry stages, fixed by the instruction set
	localparam int HEAD_STAGE = 0;
	localparam int FTOI_STAGE = 2;
	localparam int FDIV_STAGE = 13;
	localparam int FADD_STAGE = 5;
	localparam int FMUL_STAGE = 3;
	localparam int ITOF_STAGE = 2;

	// grant to beat, in cycles
	localparam int HEAD_LATENCY = HEAD_STAGE + 1;
	localparam int FTOI_LATENCY = FTOI_STAGE + 1;
	localparam int FDIV_LATENCY = FDIV_STAGE + 1;
	localparam int FADD_LATENCY = FADD_STAGE + 1;
	localparam int FMUL_LATENCY = FMUL_STAGE + 1;
	localparam int ITOF_LATENCY = ITOF_STAGE + 1;
	localparam int IN_LATENCY = 0;

	//////////////////////////////
	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;

	typedef enum logic [1:0] {
		GPR_UNIT_ADD_SUB,
		GPR_UNIT_NEXT_MOV,
		GPR_UNIT_LW,
		GPR_UNIT_FTOI
	} gpr_unit_t;

	typedef enum logic [2:0] {
		FPR_UNIT_FDIV,
		FPR_UNIT_FSQRT,
		FPR_UNIT_FADD_FSUB,
		FPR_UNIT_FMUL,
		FPR_UNIT_ITOF,
		FPR_UNIT_LW,
		FPR_UNIT_FMOV
	} fpr_unit_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t result;
	} unit_req_t;

	// quotient in result, root in result_sqrt
	typedef struct packed {
		logic valid;
		tag_t tag;
		logic is_sqrt;
		word_t result;
		word_t result_sqrt;
	} fdiv_req_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
	} cdb_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		gpr_unit_t unit;
	} gpr_slot_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		fpr_unit_t unit;
	} fpr_slot_t;

	//////////////////////////////
	// operand bypass: arch first, then a same-cycle beat, then rob
	function automatic cdb_t bypass_read(cdb_t arch, cdb_t rob, cdb_t beat);
		cdb_t r;
		logic hit;
		hit = beat.valid && beat.tag == arch.tag;
		r.valid = arch.valid || rob.valid || hit;
		r.tag = arch.tag;
		if (arch.valid) begin
			r.data = arch.data;
		end else if (hit) begin
			r.data = beat.data;
		end else begin
			r.data = rob.data;
		end
		return r;
	endfunction

endpackage

//--- fpr_result_bus.sv
`timescale 1ns/1ps

module fpr_result_bus import cdb_pkg::*; (
	input logic clk,
	input logic reset,
	input unit_req_t lw,
	input unit_req_t fmov,
	input unit_req_t fadd_fsub,
	input unit_req_t fmul,
	input unit_req_t itof,
	input unit_req_t in_req,
	input fdiv_req_t fdiv_fsqrt,
	output logic lw_ready,
	output logic fmov_ready,
	output logic fadd_fsub_ready,
	output logic fmul_ready,
	output logic itof_ready,
	output logic in_ready,
	output logic fdiv_fsqrt_ready,
	input cdb_t arch_read [N_READ],
	input cdb_t rob_read [N_READ],
	output cdb_t cdb,
	output cdb_t read [N_READ]
);
	fpr_slot_t slot [FPR_SLOTS];
	fpr_slot_t slot_next [FPR_SLOTS];
	logic lw_go;
	logic fmov_go;
	logic fadd_fsub_go;
	logic fmul_go;
	logic itof_go;
	logic in_go;
	logic fdiv_fsqrt_go;

	//////////////////////////////
	// readiness
	// a unit merges in only when the stage above its entry is empty
	assign fdiv_fsqrt_ready = 1'b1;
	assign fadd_fsub_ready = !slot[FADD_STAGE + 1].valid;
	assign fmul_ready = !slot[FMUL_STAGE + 1].valid;
	assign itof_ready = !slot[ITOF_STAGE + 1].valid;
	assign lw_ready = !slot[HEAD_STAGE + 1].valid;
	assign fmov_ready = lw_ready && !lw.valid;
	assign in_ready = !slot[HEAD_STAGE].valid;

	assign fdiv_fsqrt_go = fdiv_fsqrt.valid && fdiv_fsqrt_ready;
	assign fadd_fsub_go = fadd_fsub.valid && fadd_fsub_ready;
	assign fmul_go = fmul.valid && fmul_ready;
	assign itof_go = itof.valid && itof_ready;
	assign lw_go = lw.valid && lw_ready;
	assign fmov_go = fmov.valid && fmov_ready;
	assign in_go = in_req.valid && in_ready;

	//////////////////////////////
	// reservation register
	always_comb begin
		slot_next[FDIV_STAGE].valid = fdiv_fsqrt_go;
		slot_next[FDIV_STAGE].tag = fdiv_fsqrt.tag;
		if (fdiv_fsqrt.is_sqrt) begin
			slot_next[FDIV_STAGE].unit = FPR_UNIT_FSQRT;
		end else begin
			slot_next[FDIV_STAGE].unit = FPR_UNIT_FDIV;
		end
		for (int i = HEAD_STAGE; i < FDIV_STAGE; i++) begin
			slot_next[i] = slot[i + 1];
		end

		// staggered entry points
		if (!slot[FADD_STAGE + 1].valid) begin
			slot_next[FADD_STAGE] = '{
				valid: fadd_fsub_go,
				tag: fadd_fsub.tag,
				unit: FPR_UNIT_FADD_FSUB
			};
		end
		if (!slot[FMUL_STAGE + 1].valid) begin
			slot_next[FMUL_STAGE] = '{valid: fmul_go, tag: fmul.tag, unit: FPR_UNIT_FMUL};
		end
		if (!slot[ITOF_STAGE + 1].valid) begin
			slot_next[ITOF_STAGE] = '{valid: itof_go, tag: itof.tag, unit: FPR_UNIT_ITOF};
		end

		// lw before fmov at the head
		if (!slot[HEAD_STAGE + 1].valid) begin
			slot_next[HEAD_STAGE].valid = lw_go || fmov_go;
			if (lw_go) begin
				slot_next[HEAD_STAGE].tag = lw.tag;
				slot_next[HEAD_STAGE].unit = FPR_UNIT_LW;
			end else begin
				slot_next[HEAD_STAGE].tag = fmov.tag;
				slot_next[HEAD_STAGE].unit = FPR_UNIT_FMOV;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < FPR_SLOTS; i++) begin
			slot[i].tag <= slot_next[i].tag;
			slot[i].unit <= slot_next[i].unit;
			if (reset) begin
				slot[i].valid <= 1'b0;
			end else begin
				slot[i].valid <= slot_next[i].valid;
			end
		end
	end

	//////////////////////////////
	// bus beat
	always_comb begin
		cdb.valid = slot[HEAD_STAGE].valid || in_go;
		cdb.tag = in_req.tag;
		cdb.data = in_req.result;
		if (slot[HEAD_STAGE].valid) begin
			cdb.tag = slot[HEAD_STAGE].tag;
			case (slot[HEAD_STAGE].unit)
				FPR_UNIT_FDIV: cdb.data = fdiv_fsqrt.result;
				FPR_UNIT_FSQRT: cdb.data = fdiv_fsqrt.result_sqrt;
				FPR_UNIT_FADD_FSUB: cdb.data = fadd_fsub.result;
				FPR_UNIT_FMUL: cdb.data = fmul.result;
				FPR_UNIT_ITOF: cdb.data = itof.result;
				FPR_UNIT_LW: cdb.data = lw.result;
				FPR_UNIT_FMOV: cdb.data = fmov.result;
			endcase
		end
	end

	// operand bypass
	for (genvar i = 0; i < N_READ; i++) begin : g_read
		assign read[i] = bypass_read(arch_read[i], rob_read[i], cdb);
	end

endmodule

//--- gpr_result_bus.sv
`timescale 1ns/1ps

module gpr_result_bus import cdb_pkg::*; (
	input logic clk,
	input logic reset,
	input unit_req_t lw,
	input unit_req_t add_sub,
	input unit_req_t next,
	input unit_req_t mov,
	input unit_req_t ftoi,
	input unit_req_t in_req,
	output logic lw_ready,
	output logic add_sub_ready,
	output logic next_ready,
	output logic mov_ready,
	output logic ftoi_ready,
	output logic in_ready,
	input cdb_t arch_read [N_READ],
	input cdb_t rob_read [N_READ],
	output cdb_t cdb,
	output cdb_t read [N_READ]
);
	gpr_slot_t slot [GPR_SLOTS];
	gpr_slot_t slot_next [GPR_SLOTS];
	logic lw_go;
	logic add_sub_go;
	logic next_go;
	logic mov_go;
	logic ftoi_go;
	logic in_go;
	word_t next_mov_result;

	//////////////////////////////
	// readiness
	assign ftoi_ready = 1'b1;
	assign lw_ready = !slot[HEAD_STAGE + 1].valid;
	assign add_sub_ready = lw_ready && !lw.valid;
	assign next_ready = add_sub_ready && !add_sub.valid;
	assign mov_ready = next_ready && !next.valid;
	assign in_ready = !slot[HEAD_STAGE].valid;

	assign lw_go = lw.valid && lw_ready;
	assign add_sub_go = add_sub.valid && add_sub_ready;
	assign next_go = next.valid && next_ready;
	assign mov_go = mov.valid && mov_ready;
	assign ftoi_go = ftoi.valid && ftoi_ready;
	assign in_go = in_req.valid && in_ready;

	//////////////////////////////
	// reservation register
	always_comb begin
		slot_next[FTOI_STAGE] = '{valid: ftoi_go, tag: ftoi.tag, unit: GPR_UNIT_FTOI};
		for (int i = HEAD_STAGE; i < FTOI_STAGE; i++) begin
			slot_next[i] = slot[i + 1];
		end
		// head is free for the stage-0 units only if nothing moves down
		if (!slot[HEAD_STAGE + 1].valid) begin
			slot_next[HEAD_STAGE].valid = lw_go || add_sub_go || next_go || mov_go;
			if (lw_go) begin
				slot_next[HEAD_STAGE].tag = lw.tag;
				slot_next[HEAD_STAGE].unit = GPR_UNIT_LW;
			end else if (add_sub_go) begin
				slot_next[HEAD_STAGE].tag = add_sub.tag;
				slot_next[HEAD_STAGE].unit = GPR_UNIT_ADD_SUB;
			end else if (next_go) begin
				slot_next[HEAD_STAGE].tag = next.tag;
				slot_next[HEAD_STAGE].unit = GPR_UNIT_NEXT_MOV;
			end else begin
				slot_next[HEAD_STAGE].tag = mov.tag;
				slot_next[HEAD_STAGE].unit = GPR_UNIT_NEXT_MOV;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < GPR_SLOTS; i++) begin
			slot[i].tag <= slot_next[i].tag;
			slot[i].unit <= slot_next[i].unit;
			if (reset) begin
				slot[i].valid <= 1'b0;
			end else begin
				slot[i].valid <= slot_next[i].valid;
			end
		end
	end

	// next and mov hand over their result at grant
	always_ff @(posedge clk) begin
		if (next_go) begin
			next_mov_result <= next.result;
		end else if (mov_go) begin
			next_mov_result <= mov.result;
		end
	end

	//////////////////////////////
	// bus beat
	always_comb begin
		cdb.valid = slot[HEAD_STAGE].valid || in_go;
		cdb.tag = in_req.tag;
		cdb.data = in_req.result;
		if (slot[HEAD_STAGE].valid) begin
			cdb.tag = slot[HEAD_STAGE].tag;
			case (slot[HEAD_STAGE].unit)
				GPR_UNIT_ADD_SUB: cdb.data = add_sub.result;
				GPR_UNIT_NEXT_MOV: cdb.data = next_mov_result;
				GPR_UNIT_LW: cdb.data = lw.result;
				GPR_UNIT_FTOI: cdb.data = ftoi.result;
			endcase
		end
	end

	// operand bypass
	for (genvar i = 0; i < N_READ; i++) begin : g_read
		assign read[i] = bypass_read(arch_read[i], rob_read[i], cdb);
	end

endmodule

//--- sources.f
cdb_pkg.sv
gpr_result_bus.sv
fpr_result_bus.sv
writeback_core.sv
writeback_core_props.sv
tb_writeback_core.sv

//--- tb_writeback_core.sv
`timescale 1ns/1ps

module tb_writeback_core import cdb_pkg::*; ();
	localparam int CLK_PERIOD = 40;
	localparam integer SEED = 16618;
	localparam int RANDOM_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = 3000;

	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
		logic [3:0] unit;
	} model_slot_t;

	logic clk;
	logic reset;
	integer seed;
	int cycles;
	int mismatches;

	// gpr request order lw add_sub next mov ftoi in
	// fpr request order lw fmov fadd fmul itof in fdiv
	unit_req_t g_req [6];
	unit_req_t f_req [7];
	logic fd_sqrt;
	word_t fd_root;
	logic g_rdy [6];
	logic f_rdy [7];
	logic g_go [6];
	logic f_go [7];
	model_slot_t gm [GPR_SLOTS];
	model_slot_t gm_n [GPR_SLOTS];
	model_slot_t fm [FPR_SLOTS];
	model_slot_t fm_n [FPR_SLOTS];

	unit_req_t gpr_lw, add_sub, next, mov, ftoi, gpr_in;
	unit_req_t fpr_lw, fmov, fadd_fsub, fmul, itof, fpr_in;
	fdiv_req_t fdiv_fsqrt;
	logic gpr_lw_ready, add_sub_ready, next_ready, mov_ready, ftoi_ready, gpr_in_ready;
	logic fpr_lw_ready, fmov_ready, fadd_fsub_ready, fmul_ready, itof_ready, fpr_in_ready;
	logic fdiv_fsqrt_ready;
	cdb_t gpr_arch_read [N_READ];
	cdb_t gpr_rob_read [N_READ];
	cdb_t fpr_arch_read [N_READ];
	cdb_t fpr_rob_read [N_READ];
	cdb_t gpr_cdb, fpr_cdb;
	cdb_t gpr_read [N_READ];
	cdb_t fpr_read [N_READ];

	assign gpr_lw = g_req[0];
	assign add_sub = g_req[1];
	assign next = g_req[2];
	assign mov = g_req[3];
	assign ftoi = g_req[4];
	assign gpr_in = g_req[5];
	assign fpr_lw = f_req[0];
	assign fmov = f_req[1];
	assign fadd_fsub = f_req[2];
	assign fmul = f_req[3];
	assign itof = f_req[4];
	assign fpr_in = f_req[5];
	assign fdiv_fsqrt = {f_req[6].valid, f_req[6].tag, fd_sqrt, f_req[6].result, fd_root};

	writeback_core i_writeback_core (.*);

	always #(CLK_PERIOD/2) clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// helpers
	function automatic model_slot_t make_slot(tag_t tag, word_t data, int unit);
		model_slot_t s;
		s.valid = 1'b1;
		s.tag = tag;
		s.data = data;
		s.unit = 4'(unit);
		return s;
	endfunction

	function automatic cdb_t head_beat(model_slot_t head, unit_req_t in_req, logic in_go);
		cdb_t b;
		b = '0;
		if (head.valid) begin
			b = {1'b1, head.tag, head.data};
		end else if (in_go) begin
			b = {1'b1, in_req.tag, in_req.result};
		end
		return b;
	endfunction

	function automatic cdb_t expect_read(cdb_t arch, cdb_t rob, cdb_t beat);
		cdb_t r;
		r = '0;
		r.tag = arch.tag;
		if (arch.valid) begin
			r.valid = 1'b1;
			r.data = arch.data;
		end else if (beat.valid && beat.tag == arch.tag) begin
			r.valid = 1'b1;
			r.data = beat.data;
		end else begin
			r.valid = rob.valid;
			r.data = rob.data;
		end
		return r;
	endfunction

	function automatic cdb_t random_read();
		cdb_t r;
		r.valid = (($random(seed) & 3) == 0);
		r.tag = tag_t'($random(seed) & 32'h7);
		r.data = word_t'($random(seed));
		return r;
	endfunction

	function automatic logic unit_busy(logic is_fpr, int k);
		logic busy;
		busy = 1'b0;
		for (int i = 0; i < FPR_SLOTS; i++) begin
			if (is_fpr && fm[i].valid && fm[i].unit == 4'(k)) busy = 1'b1;
			if (!is_fpr && i < GPR_SLOTS && gm[i].valid && gm[i].unit == 4'(k)) busy = 1'b1;
		end
		return busy;
	endfunction

	function automatic logic any_pending();
		logic p;
		p = 1'b0;
		for (int i = 0; i < 7; i++) begin
			if (f_req[i].valid || (i < 6 && g_req[i].valid)) p = 1'b1;
		end
		for (int i = 0; i < FPR_SLOTS; i++) begin
			if (fm[i].valid || (i < GPR_SLOTS && gm[i].valid)) p = 1'b1;
		end
		return p;
	endfunction

	//////////////////////////////
	// compare tasks
	task automatic check_ready(string name, logic exp, logic act);
		if (exp !== act) begin
			mismatches++;
			$display("MISMATCH t=%0t %s expected=%0b actual=%0b", $time, name, exp, act);
		end
	endtask

	task automatic check_cdb(string name, cdb_t exp, cdb_t act);
		if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
			mismatches++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic check_read(string name, cdb_t exp, cdb_t act);
		if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
			mismatches++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	//////////////////////////////
	// reference model and compare
	always @(negedge clk) begin : compare_proc
		cdb_t exp_g;
		cdb_t exp_f;
		#(CLK_PERIOD/4);
		g_rdy[4] = 1'b1;
		g_rdy[0] = !gm[1].valid;
		g_rdy[1] = g_rdy[0] && !g_req[0].valid;
		g_rdy[2] = g_rdy[1] && !g_req[1].valid;
		g_rdy[3] = g_rdy[2] && !g_req[2].valid;
		g_rdy[5] = !gm[0].valid;
		f_rdy[6] = 1'b1;
		f_rdy[2] = !fm[6].valid;
		f_rdy[3] = !fm[4].valid;
		f_rdy[4] = !fm[3].valid;
		f_rdy[0] = !fm[1].valid;
		f_rdy[1] = f_rdy[0] && !f_req[0].valid;
		f_rdy[5] = !fm[0].valid;
		for (int k = 0; k < 7; k++) begin
			f_go[k] = f_req[k].valid && f_rdy[k] && !reset;
			if (k < 6) g_go[k] = g_req[k].valid && g_rdy[k] && !reset;
		end
		exp_g = head_beat(gm[0], g_req[5], g_go[5]);
		exp_f = head_beat(fm[0], f_req[5], f_go[5]);

		if (!reset) begin
			check_ready("gpr_lw_ready", g_rdy[0], gpr_lw_ready);
			check_ready("add_sub_ready", g_rdy[1], add_sub_ready);
			check_ready("next_ready", g_rdy[2], next_ready);
			check_ready("mov_ready", g_rdy[3], mov_ready);
			check_ready("ftoi_ready", g_rdy[4], ftoi_ready);
			check_ready("gpr_in_ready", g_rdy[5], gpr_in_ready);
			check_ready("fpr_lw_ready", f_rdy[0], fpr_lw_ready);
			check_ready("fmov_ready", f_rdy[1], fmov_ready);
			check_ready("fadd_fsub_ready", f_rdy[2], fadd_fsub_ready);
			check_ready("fmul_ready", f_rdy[3], fmul_ready);
			check_ready("itof_ready", f_rdy[4], itof_ready);
			check_ready("fpr_in_ready", f_rdy[5], fpr_in_ready);
			check_ready("fdiv_fsqrt_ready", f_rdy[6], fdiv_fsqrt_ready);
			check_cdb("gpr_cdb", exp_g, gpr_cdb);
			check_cdb("fpr_cdb", exp_f, fpr_cdb);
			for (int i = 0; i < N_READ; i++) begin
				check_read($sformatf("gpr_read[%0d]", i),
					expect_read(gpr_arch_read[i], gpr_rob_read[i], exp_g), gpr_read[i]);
				check_read($sformatf("fpr_read[%0d]", i),
					expect_read(fpr_arch_read[i], fpr_rob_read[i], exp_f), fpr_read[i]);
			end
		end

		// gpr next state
		gm_n[2] = g_go[4] ? make_slot(g_req[4].tag, g_req[4].result, 4) : '0;
		gm_n[1] = gm[2];
		gm_n[0] = gm[1];
		if (!gm[1].valid) begin
			gm_n[0] = '0;
			for (int k = 0; k < 4; k++) begin
				if (g_go[k] && !gm_n[0].valid) begin
					gm_n[0] = make_slot(g_req[k].tag, g_req[k].result, k);
				end
			end
		end

		// fpr next state
		fm_n[13] = '0;
		if (f_go[6]) fm_n[13] = make_slot(f_req[6].tag, fd_sqrt ? fd_root : f_req[6].result, 6);
		for (int i = 0; i < FDIV_STAGE; i++) begin
			fm_n[i] = fm[i + 1];
		end
		if (!fm[6].valid) fm_n[5] = f_go[2] ? make_slot(f_req[2].tag, f_req[2].result, 2) : '0;
		if (!fm[4].valid) fm_n[3] = f_go[3] ? make_slot(f_req[3].tag, f_req[3].result, 3) : '0;
		if (!fm[3].valid) fm_n[2] = f_go[4] ? make_slot(f_req[4].tag, f_req[4].result, 4) : '0;
		if (!fm[1].valid) begin
			fm_n[0] = '0;
			if (f_go[0]) fm_n[0] = make_slot(f_req[0].tag, f_req[0].result, 0);
			else if (f_go[1]) fm_n[0] = make_slot(f_req[1].tag, f_req[1].result, 1);
		end

		@(posedge clk);
		for (int i = 0; i < FPR_SLOTS; i++) begin
			fm[i] = fm_n[i];
			if (reset) fm[i].valid = 1'b0;
			if (i < GPR_SLOTS) begin
				gm[i] = gm_n[i];
				if (reset) gm[i].valid = 1'b0;
			end
		end
	end

	//////////////////////////////
	// stimulus
	task automatic set_gpr(int k);
		g_req[k] = {1'b1, tag_t'($random(seed) & 32'h7), word_t'($random(seed))};
	endtask

	task automatic set_fpr(int k);
		f_req[k] = {1'b1, tag_t'($random(seed) & 32'h7), word_t'($random(seed))};
		if (k == 6) fd_root = word_t'($random(seed));
	endtask

	// drop granted requests and draw new operand reads
	task automatic tick();
		@(negedge clk);
		for (int k = 0; k < 7; k++) begin
			if (f_go[k]) f_req[k].valid = 1'b0;
			if (k < 6 && g_go[k]) g_req[k].valid = 1'b0;
		end
		for (int i = 0; i < N_READ; i++) begin
			gpr_arch_read[i] = random_read();
			gpr_rob_read[i] = random_read();
			fpr_arch_read[i] = random_read();
			fpr_rob_read[i] = random_read();
		end
	endtask

	task automatic wait_idle();
		tick();
		while (any_pending()) tick();
	endtask

	task automatic drive_random();
		for (int k = 0; k < 7; k++) begin
			if (!f_req[k].valid && !unit_busy(1'b1, k) && ($random(seed) & 3) == 0) begin
				set_fpr(k);
				if (k == 6) fd_sqrt = $random(seed) & 1;
			end
			if (k < 6 && !g_req[k].valid && !unit_busy(1'b0, k) && ($random(seed) & 3) == 0) begin
				set_gpr(k);
			end
		end
	endtask

	initial begin
		seed = SEED;
		clk = 1'b0;
		reset = 1'b1;
		cycles = 0;
		mismatches = 0;
		fd_sqrt = 1'b0;
		fd_root = '0;
		for (int k = 0; k < 7; k++) begin
			f_req[k] = '0;
			f_go[k] = 1'b0;
			if (k < 6) g_req[k] = '0;
			if (k < 6) g_go[k] = 1'b0;
		end
		for (int i = 0; i < FPR_SLOTS; i++) begin
			fm[i] = '0;
			if (i < GPR_SLOTS) gm[i] = '0;
		end
		for (int i = 0; i < N_READ; i++) begin
			gpr_arch_read[i] = '0;
			gpr_rob_read[i] = '0;
			fpr_arch_read[i] = '0;
			fpr_rob_read[i] = '0;
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// lone request per unit
		for (int k = 0; k < 6; k++) begin
			tick();
			set_gpr(k);
			wait_idle();
		end
		for (int k = 0; k < 8; k++) begin
			tick();
			fd_sqrt = (k == 7);
			set_fpr(k < 7 ? k : 6);
			wait_idle();
		end

		// gpr priority
		tick();
		for (int k = 0; k < 4; k++) set_gpr(k);
		wait_idle();

		// ftoi reservation blocks the head
		tick();
		set_gpr(4);
		repeat (2) tick();
		set_gpr(0);
		set_gpr(5);
		wait_idle();

		// fdiv reservation blocks the merge points
		tick();
		set_fpr(6);
		repeat (8) tick();
		for (int k = 0; k < 6; k++) set_fpr(k);
		wait_idle();

		// reset with an fdiv in flight
		tick();
		set_fpr(6);
		repeat (5) tick();
		reset = 1'b1;
		repeat (2) tick();
		reset = 1'b0;
		wait_idle();

		repeat (RANDOM_CYCLES) begin
			tick();
			drive_random();
		end
		wait_idle();
		repeat (2) tick();

		$display("errors: %0d mismatches", mismatches);
		if (mismatches == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- writeback_core.sv
`timescale 1ns/1ps

module writeback_core import cdb_pkg::*; (
	input logic clk,
	input logic reset,

	// gpr side
	input unit_req_t gpr_lw,
	input unit_req_t add_sub,
	input unit_req_t next,
	input unit_req_t mov,
	input unit_req_t ftoi,
	input unit_req_t gpr_in,
	output logic gpr_lw_ready,
	output logic add_sub_ready,
	output logic next_ready,
	output logic mov_ready,
	output logic ftoi_ready,
	output logic gpr_in_ready,
	input cdb_t gpr_arch_read [N_READ],
	input cdb_t gpr_rob_read [N_READ],
	output cdb_t gpr_cdb,
	output cdb_t gpr_read [N_READ],

	// fpr side
	input unit_req_t fpr_lw,
	input unit_req_t fmov,
	input unit_req_t fadd_fsub,
	input unit_req_t fmul,
	input unit_req_t itof,
	input unit_req_t fpr_in,
	input fdiv_req_t fdiv_fsqrt,
	output logic fpr_lw_ready,
	output logic fmov_ready,
	output logic fadd_fsub_ready,
	output logic fmul_ready,
	output logic itof_ready,
	output logic fpr_in_ready,
	output logic fdiv_fsqrt_ready,
	input cdb_t fpr_arch_read [N_READ],
	input cdb_t fpr_rob_read [N_READ],
	output cdb_t fpr_cdb,
	output cdb_t fpr_read [N_READ]
);

	gpr_result_bus i_gpr_result_bus (
		.clk,
		.reset,
		.lw(gpr_lw),
		.add_sub,
		.next,
		.mov,
		.ftoi,
		.in_req(gpr_in),
		.lw_ready(gpr_lw_ready),
		.add_sub_ready,
		.next_ready,
		.mov_ready,
		.ftoi_ready,
		.in_ready(gpr_in_ready),
		.arch_read(gpr_arch_read),
		.rob_read(gpr_rob_read),
		.cdb(gpr_cdb),
		.read(gpr_read)
	);

	fpr_result_bus i_fpr_result_bus (
		.clk,
		.reset,
		.lw(fpr_lw),
		.fmov,
		.fadd_fsub,
		.fmul,
		.itof,
		.in_req(fpr_in),
		.fdiv_fsqrt,
		.lw_ready(fpr_lw_ready),
		.fmov_ready,
		.fadd_fsub_ready,
		.fmul_ready,
		.itof_ready,
		.in_ready(fpr_in_ready),
		.fdiv_fsqrt_ready,
		.arch_read(fpr_arch_read),
		.rob_read(fpr_rob_read),
		.cdb(fpr_cdb),
		.read(fpr_read)
	);

endmodule

//--- writeback_core_props.sv
`timescale 1ns/1ps

module writeback_core_props import cdb_pkg::*; (
	input logic clk,
	input logic reset,
	input unit_req_t gpr_in,
	input unit_req_t fpr_in,
	input unit_req_t gpr_lw,
	input logic mov_ready,
	input fdiv_req_t fdiv_fsqrt,
	input logic fdiv_fsqrt_ready,
	input cdb_t gpr_cdb,
	input cdb_t fpr_cdb
);

	//////////////////////////////
	// empty buses right after reset
	assert property (@(posedge clk)
		reset |=> ((!gpr_cdb.valid || gpr_in.valid) && (!fpr_cdb.valid || fpr_in.valid)))
		else $error("bus beat seen in the cycle after reset");

	// fdiv and fsqrt land on the bus after their full latency
	assert property (@(posedge clk) disable iff (reset)
		(fdiv_fsqrt.valid && fdiv_fsqrt_ready) |-> ##FDIV_LATENCY fpr_cdb.valid)
		else $error("fdiv grant without an fpr beat 14 cycles later");

	// lw outranks mov
	assert property (@(posedge clk) disable iff (reset)
		gpr_lw.valid |-> !mov_ready)
		else $error("mov ready while lw is valid");

endmodule

bind writeback_core writeback_core_props i_writeback_core_props (.*);
